/* design/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// bus widths
`define CACHE_DATA_W		32
`define CACHE_ADDR_W		32

// two ways of 16 sets each
`define CACHE_SETS		16
`define CACHE_INDEX_W		4

// four 32-bit words per line
`define CACHE_LINE_WORDS	4
`define CACHE_OFFSET_W		2

// address split, msb first
// tag | index | word offset | byte (ignored)
`define CACHE_TAG_W		24
`define CACHE_BYTE_W		2

`endif

/* design/cache_pkg.sv */
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

	// processor address broken into its fields
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0]	tag;
		logic [`CACHE_INDEX_W-1:0]	index;
		logic [`CACHE_OFFSET_W-1:0]	offset;
		logic [`CACHE_BYTE_W-1:0]	byte_bits;	// always ignored
	} addr_fields_t;

	typedef union packed {
		logic [`CACHE_ADDR_W-1:0]	word;
		addr_fields_t			f;
	} cache_addr_u;

	typedef struct packed {
		logic				valid;
		logic				dirty;
		logic [`CACHE_TAG_W-1:0]	tag;
	} tag_entry_t;

	typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_DATA_W-1:0] cache_line_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic				cyc;
		logic				stb;
		logic				we;
		logic [`CACHE_ADDR_W-1:0]	adr;
		logic [`CACHE_DATA_W-1:0]	dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic				ack;
		logic [`CACHE_DATA_W-1:0]	dat;
	} wb_rsp_t;

	typedef logic way_t;

endpackage

`default_nettype wire

/* design/tag_store.sv */
`default_nettype none
`include "cache_defs.svh"

module tag_store (
	input  logic			clk,
	input  logic			reset,
	input  cache_pkg::cache_addr_u	lookup_addr,
	input  logic			wr_en,
	input  cache_pkg::way_t		wr_way,
	input  cache_pkg::tag_entry_t	wr_entry,
	input  logic			touch,
	input  cache_pkg::way_t		touch_way,
	output logic			hit,
	output cache_pkg::way_t		hit_way,
	output cache_pkg::way_t		victim_way,
	output cache_pkg::tag_entry_t	victim_entry
);

	cache_pkg::tag_entry_t [1:0][`CACHE_SETS-1:0]	entries;
	logic [`CACHE_SETS-1:0]				lru;	// way to evict next, per set
	logic [`CACHE_INDEX_W-1:0]			idx;
	logic [1:0]					match;

	assign idx = lookup_addr.f.index;

	// compare both ways of the set at once
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w] = entries[w][idx].valid && (entries[w][idx].tag == lookup_addr.f.tag);
		end
	end

	assign hit          = |match;
	assign hit_way      = match[1];
	assign victim_way   = lru[idx];
	assign victim_entry = entries[victim_way][idx];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			entries <= '0;
			lru     <= '0;
		end else begin
			if (wr_en)
				entries[wr_way][idx] <= wr_entry;
			if (touch)
				lru[idx] <= ~touch_way;	// other way becomes the victim
		end
	end

endmodule

`default_nettype wire

/* design/data_store.sv */
`default_nettype none
`include "cache_defs.svh"

module data_store (
	input  logic				clk,
	input  logic [`CACHE_INDEX_W-1:0]	index,
	input  logic [`CACHE_OFFSET_W-1:0]	offset,
	input  cache_pkg::way_t			way,
	input  logic				word_wr,
	input  logic [`CACHE_DATA_W-1:0]	word_data,
	input  logic				line_wr,
	input  cache_pkg::cache_line_t		line_data,
	output logic [`CACHE_DATA_W-1:0]	rd_word,
	output cache_pkg::cache_line_t		rd_line
);

	// line array, way then set
	cache_pkg::cache_line_t	lines [2][`CACHE_SETS];

	// asynchronous read of the selected way
	assign rd_line = lines[way][index];
	assign rd_word = rd_line[offset];

	always_ff @(posedge clk) begin
		if (line_wr) begin
			lines[way][index] <= line_data;	// refill replaces the whole line
		end else if (word_wr) begin
			lines[way][index][offset] <= word_data;
		end
	end

endmodule

`default_nettype wire

/* design/line_transfer.sv */
`default_nettype none
`include "cache_defs.svh"

module line_transfer (
	input  logic				clk,
	input  logic				reset,
	input  logic				start,
	input  logic				write_back,
	input  logic [`CACHE_ADDR_W-1:0]	line_addr,
	input  cache_pkg::cache_line_t		wb_line,
	output cache_pkg::wb_req_t		mem_req,
	input  cache_pkg::wb_rsp_t		mem_rsp,
	output logic				done,
	output cache_pkg::cache_line_t		fill_line
);

	logic				active;		// a line is on the bus
	logic				we_q;
	logic [`CACHE_OFFSET_W-1:0]	word_cnt;
	logic [`CACHE_ADDR_W-1:0]	base;
	logic				launch;
	logic				beat;		// current word acknowledged
	logic				last;

	assign launch = start && !active;
	assign beat   = active && mem_rsp.ack;
	assign last   = &word_cnt;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			active   <= 1'b0;
			we_q     <= 1'b0;
			word_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (launch) begin
				active   <= 1'b1;
				we_q     <= write_back;
				word_cnt <= '0;
			end else if (beat) begin
				word_cnt <= word_cnt + 1'b1;
				if (last) begin
					// fourth ack ends the line, done follows a cycle later
					active <= 1'b0;
					we_q   <= 1'b0;
					done   <= 1'b1;
				end
			end
		end
	end

	// line base and refill data
	always_ff @(posedge clk) begin
		if (launch)
			base <= line_addr;
		if (beat && !we_q)
			fill_line[word_cnt] <= mem_rsp.dat;
	end

	// request held until acked, next word follows straight after
	always_comb begin
		mem_req.cyc = active;
		mem_req.stb = active;
		mem_req.we  = we_q;
		mem_req.adr = {base[`CACHE_ADDR_W-1:`CACHE_OFFSET_W+`CACHE_BYTE_W], word_cnt,
			{`CACHE_BYTE_W{1'b0}}};
		mem_req.dat = wb_line[word_cnt];	// don't care on reads
	end

endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_ctrl (
	input  logic				clk,
	input  logic				reset,
	input  cache_pkg::wb_req_t		cpu_req,
	output cache_pkg::wb_rsp_t		cpu_rsp,
	// tag store
	output cache_pkg::cache_addr_u		lookup_addr,
	output logic				wr_en,
	output cache_pkg::way_t			wr_way,
	output cache_pkg::tag_entry_t		wr_entry,
	output logic				touch,
	output cache_pkg::way_t			touch_way,
	input  logic				hit,
	input  cache_pkg::way_t			hit_way,
	input  cache_pkg::way_t			victim_way,
	input  cache_pkg::tag_entry_t		victim_entry,
	// data store
	output cache_pkg::way_t			data_way,
	output logic				word_wr,
	output logic [`CACHE_DATA_W-1:0]	word_data,
	output logic				line_wr,
	output cache_pkg::cache_line_t		line_data,
	input  logic [`CACHE_DATA_W-1:0]	rd_word,
	input  cache_pkg::cache_line_t		rd_line,
	// line transfer engine
	output logic				start,
	output logic				write_back,
	output logic [`CACHE_ADDR_W-1:0]	line_addr,
	output cache_pkg::cache_line_t		wb_line,
	input  logic				done,
	input  cache_pkg::cache_line_t		fill_line
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RESPOND,
		S_WRITE_BACK,
		S_REFILL,
		S_INSTALL
	} state_t;

	state_t				state;
	state_t				next_state;
	logic				lookup;		// idle with a live strobe
	logic				ack_q;
	logic [`CACHE_DATA_W-1:0]	rdata_q;
	cache_pkg::cache_addr_u		base;

	// processor holds adr, we and dat until ack, so no address latch
	assign lookup_addr.word = cpu_req.adr;
	assign lookup = (state == S_IDLE) && cpu_req.cyc && cpu_req.stb;

	// hit path
	assign touch     = lookup && hit;
	assign touch_way = hit_way;
	assign word_wr   = touch && cpu_req.we;
	assign word_data = cpu_req.dat;
	assign data_way  = hit ? hit_way : victim_way;
	assign line_wr   = (state == S_INSTALL);
	assign line_data = fill_line;

	// dirty on a write hit, clean valid entry on install
	always_comb begin
		wr_en          = word_wr || line_wr;
		wr_way         = line_wr ? victim_way : hit_way;
		wr_entry.valid = 1'b1;
		wr_entry.dirty = !line_wr;
		wr_entry.tag   = lookup_addr.f.tag;
	end

	// miss path
	assign write_back = lookup && !hit && victim_entry.valid && victim_entry.dirty;
	assign start      = (lookup && !hit) || ((state == S_WRITE_BACK) && done);

	// line base, victim tag while writing back
	always_comb begin
		base             = lookup_addr;
		base.f.offset    = '0;
		base.f.byte_bits = '0;
		if (write_back)
			base.f.tag = victim_entry.tag;
	end
	assign line_addr = base.word;

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (lookup) begin
					if (hit)
						next_state = S_RESPOND;
					else if (write_back)
						next_state = S_WRITE_BACK;
					else
						next_state = S_REFILL;
				end
			end
			S_RESPOND:    next_state = S_IDLE;	// ack cycle, stb ignored
			S_WRITE_BACK: if (done) next_state = S_REFILL;
			S_REFILL:     if (done) next_state = S_INSTALL;
			S_INSTALL:    next_state = S_IDLE;	// lookup again, now a hit
			default:      next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= S_IDLE;
			ack_q <= 1'b0;
		end else begin
			state <= next_state;
			ack_q <= touch;
		end
	end

	always_ff @(posedge clk) begin
		if (touch)
			rdata_q <= rd_word;
		if (write_back)
			wb_line <= rd_line;	// victim line, data_way is the victim on a miss
	end

	assign cpu_rsp.ack = ack_q;
	assign cpu_rsp.dat = rdata_q;

endmodule

`default_nettype wire

/* design/wb_cache_top.sv */
`default_nettype none
`include "cache_defs.svh"

module wb_cache_top (
	input  logic			clk,
	input  logic			reset,
	input  cache_pkg::wb_req_t	cpu_req,
	output cache_pkg::wb_rsp_t	cpu_rsp,
	output cache_pkg::wb_req_t	mem_req,
	input  cache_pkg::wb_rsp_t	mem_rsp
);

	// tag store
	cache_pkg::cache_addr_u		lookup_addr;
	logic				wr_en;
	cache_pkg::way_t		wr_way;
	cache_pkg::tag_entry_t		wr_entry;
	logic				touch;
	cache_pkg::way_t		touch_way;
	logic				hit;
	cache_pkg::way_t		hit_way;
	cache_pkg::way_t		victim_way;
	cache_pkg::tag_entry_t		victim_entry;

	// data store
	cache_pkg::way_t		data_way;
	logic				word_wr;
	logic [`CACHE_DATA_W-1:0]	word_data;
	logic				line_wr;
	cache_pkg::cache_line_t		line_data;
	logic [`CACHE_DATA_W-1:0]	rd_word;
	cache_pkg::cache_line_t		rd_line;

	// line transfer
	logic				start;
	logic				write_back;
	logic [`CACHE_ADDR_W-1:0]	line_addr;
	cache_pkg::cache_line_t		wb_line;
	logic				done;
	cache_pkg::cache_line_t		fill_line;

	cache_ctrl u_ctrl (.*);

	tag_store u_tags (.*);

	data_store u_data (
		.index	(lookup_addr.f.index),
		.offset	(lookup_addr.f.offset),
		.way	(data_way),
		.*
	);

	line_transfer u_xfer (.*);

endmodule

`default_nettype wire

/* tb/cache_mem_model.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_mem_model (
	input  logic			clk,
	input  logic			reset,
	input  cache_pkg::wb_req_t	req,
	output cache_pkg::wb_rsp_t	rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 4096;

	logic [`CACHE_DATA_W-1:0]	mem [MEM_WORDS];	// contents loaded by the testbench
	logic [31:0]			rand_state;
	logic [1:0]			wait_left;
	logic				waiting;	// request seen, counting wait states
	logic [11:0]			word_idx;
	int				cycle_cnt;
	int				write_cnt;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign word_idx = req.adr[13:2];

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			rsp        <= '0;
			waiting    <= 1'b0;
			wait_left  <= '0;
			rand_state <= 32'hd249_10fa;
			cycle_cnt  <= 0;
			write_cnt  <= 0;
		end else begin
			rsp.ack <= 1'b0;
			if (rsp.ack) begin
				// stb ignored for one cycle after an ack
			end else if (req.cyc && req.stb) begin
				if (!waiting) begin
					waiting    <= 1'b1;
					wait_left  <= rand_state[1:0];	// 0 to 3 wait states
					rand_state <= xorshift32(rand_state);
				end else if (wait_left != 0) begin
					wait_left <= wait_left - 1'b1;
				end else begin
					waiting   <= 1'b0;
					rsp.ack   <= 1'b1;
					rsp.dat   <= mem[word_idx];
					cycle_cnt <= cycle_cnt + 1;
					if (req.we) begin
						mem[word_idx] <= req.dat;
						write_cnt     <= write_cnt + 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb/cache_properties.sv */
`default_nettype none

module cache_properties (
	input logic			clk,
	input logic			reset,
	input cache_pkg::wb_req_t	cpu_req,
	input cache_pkg::wb_rsp_t	cpu_rsp,
	input cache_pkg::wb_req_t	mem_req,
	input cache_pkg::wb_rsp_t	mem_rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	int violations = 0;	// failure count, polled by the testbench

	cpu_ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
		cpu_rsp.ack |-> cpu_req.cyc && cpu_req.stb)
		else begin violations++; $error("processor ack without cyc and stb"); end
	mem_ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
		mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
		else begin violations++; $error("memory ack without cyc and stb"); end

	// single-cycle acks on both ports
	cpu_ack_one_cycle: assert property (@(posedge clk) disable iff (!reset)
		cpu_rsp.ack |=> !cpu_rsp.ack)
		else begin violations++; $error("processor ack held longer than one cycle"); end
	mem_ack_one_cycle: assert property (@(posedge clk) disable iff (!reset)
		mem_rsp.ack |=> !mem_rsp.ack)
		else begin violations++; $error("memory ack held longer than one cycle"); end

	mem_stb_in_cyc: assert property (@(posedge clk) disable iff (!reset)
		mem_req.stb |-> mem_req.cyc)
		else begin violations++; $error("memory stb raised outside cyc"); end

	cpu_req_held: assert property (@(posedge clk) disable iff (!reset)
		cpu_req.stb && !cpu_rsp.ack |=> $stable(cpu_req.adr) && $stable(cpu_req.we))
		else begin violations++; $error("processor adr or we changed before ack"); end
	mem_req_held: assert property (@(posedge clk) disable iff (!reset)
		mem_req.stb && !mem_rsp.ack |=> $stable(mem_req.adr) && $stable(mem_req.we))
		else begin violations++; $error("memory adr or we changed before ack"); end

	reset_state: assert property (@(posedge clk)
		$rose(reset) |-> !cpu_rsp.ack && !mem_req.cyc)
		else begin violations++; $error("ack or memory cyc high after reset"); end

endmodule

bind wb_cache_top cache_properties u_props (.*);

`default_nettype wire

/* tb/cache_tb.sv */
`default_nettype none
`include "cache_defs.svh"

module cache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS   = 4096;
	localparam time DRIVE_DLY  = 2;
	localparam int RAND_OPS    = 48;
	localparam int ACCESSES    = 2 + 2 + 4 + 6 + RAND_OPS;
	// eight memory words at up to 6 cycles each, plus lookup, install and bus gaps
	localparam int MISS_CYCLES = 8 * 6 + 12;
	localparam int CYCLE_LIMIT = ACCESSES * MISS_CYCLES + 20;

	logic			clk;
	logic			reset;
	cache_pkg::wb_req_t	cpu_req;
	cache_pkg::wb_rsp_t	cpu_rsp;
	cache_pkg::wb_req_t	mem_req;
	cache_pkg::wb_rsp_t	mem_rsp;

	logic [`CACHE_DATA_W-1:0]	ref_mem [MEM_WORDS];	// what the processor should see
	logic [31:0]			rand_state = 32'hd249_10fa;
	int				cycle_cnt = 0;

	wb_cache_top u_dut (.*);

	cache_mem_model u_mem (
		.clk	(clk),
		.reset	(reset),
		.req	(mem_req),
		.rsp	(mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (u_dut.u_props.violations != 0) begin
			$display("bus protocol assertion failed, see the error above");
			$display("FAIL: see errors above");
			$fatal(1, "bus protocol violated");
		end else if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: no end of test after %0d cycles", cycle_cnt);
			$display("FAIL: see errors above");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// distinct per word, both halves carry the index
	function automatic logic [31:0] init_word(input int i);
		logic [11:0] w;
		w = i[11:0];
		return {4'ha, w, 4'h5, ~w};
	endfunction

	function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
		logic [23:0] t;
		logic [3:0] s;
		logic [1:0] o;
		t = tag[23:0];
		s = set[3:0];
		o = word[1:0];
		return {t, s, o, 2'b00};
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one classic cycle, returns data, cycles to ack and memory cycles used
	task automatic cpu_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, output int lat, output int mcyc);
		int mem_start;
		@(posedge clk);
		#DRIVE_DLY;
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		cpu_req.we  = we;
		cpu_req.adr = adr;
		cpu_req.dat = wdat;
		mem_start   = u_mem.cycle_cnt;
		lat         = 0;
		do begin
			@(posedge clk);
			lat++;
			@(negedge clk);	// ack and data settled mid-cycle
		end while (!cpu_rsp.ack);
		rdat = cpu_rsp.dat;
		mcyc = u_mem.cycle_cnt - mem_start;
		@(posedge clk);
		#DRIVE_DLY;
		cpu_req = '0;
	endtask

	task automatic read_check(input logic [31:0] adr, output int lat, output int mcyc);
		logic [31:0] rdat;
		cpu_access(1'b0, adr, '0, rdat, lat, mcyc);
		check_equal(rdat, ref_mem[adr[13:2]], "read data");
	endtask

	task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat, output int mcyc);
		logic [31:0] rdat;
		int lat;
		cpu_access(1'b1, adr, wdat, rdat, lat, mcyc);
		ref_mem[adr[13:2]] = wdat;
	endtask

	task automatic read_miss_then_hit();
		logic [31:0] a;
		int lat;
		int mc;
		a = make_addr(1, 3, 2);
		read_check(a, lat, mc);
		check_equal(mc, 4, "memory cycles on read miss");
		read_check(a, lat, mc);
		check_equal(mc, 0, "memory cycles on read hit");
		check_equal(lat, 1, "read hit latency");
	endtask

	task automatic write_hit_readback();
		logic [31:0] a;
		int lat;
		int mc;
		a = make_addr(1, 3, 1);	// same line as the previous test
		write_word(a, 32'hdead_beef, mc);
		check_equal(mc, 0, "memory cycles on write hit");
		read_check(a, lat, mc);
		check_equal(mc, 0, "memory cycles on read after write hit");
		check_equal(u_mem.mem[a[13:2]], init_word(a[13:2]), "memory word after write hit");
	endtask

	task automatic dirty_eviction();
		logic [31:0] a;
		int lat;
		int mc;
		int wr_start;
		a = make_addr(2, 5, 0);
		write_word(a, 32'h1357_9bdf, mc);
		check_equal(mc, 4, "memory cycles on write miss");
		read_check(make_addr(3, 5, 0), lat, mc);
		check_equal(mc, 4, "memory cycles on miss into free way");
		wr_start = u_mem.write_cnt;
		read_check(make_addr(4, 5, 0), lat, mc);
		check_equal(mc, 8, "memory cycles on dirty eviction");
		check_equal(u_mem.write_cnt - wr_start, 4, "memory writes on dirty eviction");
		check_equal(u_mem.mem[a[13:2]], 32'h1357_9bdf, "memory word after write-back");
		read_check(a, lat, mc);
	endtask

	task automatic lru_victim();
		int lat;
		int mc;
		read_check(make_addr(5, 7, 0), lat, mc);
		read_check(make_addr(6, 7, 0), lat, mc);
		read_check(make_addr(5, 7, 0), lat, mc);	// A most recent again
		check_equal(mc, 0, "memory cycles on touch of A");
		read_check(make_addr(7, 7, 0), lat, mc);
		read_check(make_addr(5, 7, 0), lat, mc);
		check_equal(mc, 0, "memory cycles on A after miss on C");
		read_check(make_addr(6, 7, 0), lat, mc);
		check_equal(mc, 4, "memory cycles on evicted B");
	endtask

	// four tags over four sets, so ways fill up and lines get evicted
	task automatic random_traffic();
		logic [31:0] r;
		logic [31:0] adr;
		int lat;
		int mc;
		for (int n = 0; n < RAND_OPS; n++) begin
			rand_state = xorshift32(rand_state);
			r          = rand_state;
			adr        = make_addr(8 + r[3:2], 12 + r[1:0], r[5:4]);
			if (r[6]) begin
				rand_state = xorshift32(rand_state);
				write_word(adr, rand_state, mc);
			end else begin
				read_check(adr, lat, mc);
			end
		end
	endtask

	initial begin
		reset   = 1'b0;
		cpu_req = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i]   = init_word(i);
			u_mem.mem[i] = ref_mem[i];
		end
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		reset = 1'b1;

		read_miss_then_hit();
		write_hit_readback();
		dirty_eviction();
		lru_victim();
		random_traffic();

		repeat (2) @(posedge clk);
		if (u_dut.u_props.violations != 0) begin
			$display("%0d bus assertion failures", u_dut.u_props.violations);
			$display("FAIL: see errors above");
			$fatal(1, "bus protocol violated");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* wb_cache.f */
+incdir+design
design/cache_pkg.sv
design/tag_store.sv
design/data_store.sv
design/line_transfer.sv
design/cache_ctrl.sv
design/wb_cache_top.sv
tb/cache_mem_model.sv
tb/cache_properties.sv
tb/cache_tb.sv
